/* source/icache_pkg.sv */
package icache_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    typedef logic [ADDR_W-1:0] addr_t; // Byte address
    typedef logic [WORD_W-1:0] word_t;

    // Cache to block reader
    typedef struct packed {
        logic  request;  // Level, held until last beat
        addr_t addr;     // Block aligned
    } mem_req_t;

    // Block reader to cache
    typedef struct packed {
        logic  data_ready; // One strobe per word
        word_t data;
    } mem_rsp_t;

    // External image load into the reader
    typedef struct packed {
        logic  we;
        addr_t addr;
        word_t data;
    } load_req_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL
    } cache_state_e;

endpackage

/* source/icache_replace.sv */
module icache_replace #(
    parameter int NUM_SETS = 8,
    parameter int NUM_WAYS = 4
) (
    input  logic                        Clk,
    input  logic                        rst,
    input  logic [$clog2(NUM_SETS)-1:0] set,
    input  logic [NUM_WAYS-1:0]         valid_ways,
    input  logic                        fill,
    output logic [$clog2(NUM_WAYS)-1:0] victim
);

    localparam int WAY_W = $clog2(NUM_WAYS);

    typedef logic [WAY_W-1:0] way_t;

    way_t rr_ptr [NUM_SETS]; // One round-robin pointer per set
    way_t first_invalid;
    logic all_valid;

    assign all_valid = &valid_ways;

    // Walk down so the lowest invalid way wins
    always_comb begin
        first_invalid = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_ways[w]) begin
                first_invalid = way_t'(w);
            end
        end
    end

    assign victim = all_valid ? rr_ptr[set] : first_invalid;

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else if (fill && all_valid) begin
            if (rr_ptr[set] == way_t'(NUM_WAYS - 1)) begin
                rr_ptr[set] <= '0;
            end else begin
                rr_ptr[set] <= rr_ptr[set] + 1'b1;
            end
        end
    end

endmodule

/* source/sdram_block_reader.sv */
module sdram_block_reader #(
    parameter int MEM_WORDS   = 1024,
    parameter int MEM_LATENCY = 3,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                  Clk,
    input  logic                  rst,
    input  icache_pkg::mem_req_t  mem_req,
    output icache_pkg::mem_rsp_t  mem_rsp,
    input  icache_pkg::load_req_t load
);

    import icache_pkg::*;

    localparam int MEM_AW = $clog2(MEM_WORDS);
    localparam int LAT_W  = $clog2(MEM_LATENCY + 1);
    localparam int BEAT_W = $clog2(BLOCK_WORDS + 1);

    typedef logic [MEM_AW-1:0] mem_idx_t;

    typedef enum logic [1:0] {
        R_IDLE,
        R_WAIT,
        R_BURST,
        R_DONE
    } reader_state_e;

    reader_state_e state;

    word_t      mem [MEM_WORDS];
    mem_idx_t   base_idx;
    mem_idx_t   rd_idx;
    mem_idx_t   load_idx;
    logic [LAT_W-1:0]  lat_cnt;
    logic [BEAT_W-1:0] beat;
    logic       issue;   // A word goes out on this edge
    logic       data_ready;
    word_t      rsp_data;

    assign load_idx = load.addr[2 +: MEM_AW]; // Word index, wraps at MEM_WORDS
    assign rd_idx   = base_idx + mem_idx_t'(beat);

    // Latency must be at least two cycles
    always_comb begin
        issue = 1'b0;
        case (state)
            R_WAIT:  issue = (lat_cnt == LAT_W'(MEM_LATENCY - 1));
            R_BURST: issue = (beat != BEAT_W'(BLOCK_WORDS));
            default: issue = 1'b0;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            state      <= R_IDLE;
            lat_cnt    <= '0;
            beat       <= '0;
            data_ready <= 1'b0;
        end else begin
            data_ready <= issue;
            if (issue) begin
                beat <= beat + 1'b1;
            end
            case (state)
                R_IDLE: begin
                    if (mem_req.request) begin
                        state   <= R_WAIT;
                        lat_cnt <= LAT_W'(1);
                        beat    <= '0;
                    end
                end
                R_WAIT: begin
                    if (issue) begin
                        state <= R_BURST;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                R_BURST: begin
                    if (!issue) begin
                        state <= R_DONE;
                    end
                end
                R_DONE: begin
                    if (!mem_req.request) begin // Wait for the cache to let go
                        state <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (load.we) begin
            mem[load_idx] <= load.data;
        end
        if (state == R_IDLE && mem_req.request) begin
            base_idx <= mem_req.addr[2 +: MEM_AW];
        end
        if (issue) begin
            rsp_data <= mem[rd_idx];
        end
    end

    assign mem_rsp = '{data_ready: data_ready, data: rsp_data};

endmodule

/* source/icache.sv */
module icache #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                 Clk,
    input  logic                 rst,
    input  logic                 read_enable,
    input  icache_pkg::addr_t    read_address,
    output icache_pkg::word_t    instruction,
    output logic                 ready,
    output logic                 busy,
    output icache_pkg::mem_req_t mem_req,
    input  icache_pkg::mem_rsp_t mem_rsp
);

    import icache_pkg::*;

    localparam int SET_W = $clog2(NUM_SETS);
    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int OFF_W = $clog2(BLOCK_WORDS);
    localparam int TAG_W = ADDR_W - SET_W - OFF_W - 2;

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [SET_W-1:0] set_idx_t;
    typedef logic [WAY_W-1:0] way_t;
    typedef logic [OFF_W-1:0] offset_t;

    cache_state_e state;

    tag_t  tag_mem  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    word_t data_mem [NUM_SETS][NUM_WAYS][BLOCK_WORDS];
    word_t fill_buf [BLOCK_WORDS];

    addr_t    req_addr;  // Address captured at acceptance
    tag_t     req_tag;
    set_idx_t req_set;
    offset_t  req_off;
    addr_t    block_addr;

    logic     hit;
    way_t     hit_way;
    way_t     victim;
    logic     fill;
    logic     fill_done; // All beats in, write on next edge
    offset_t  fill_cnt;
    logic     mem_request;

    assign req_tag    = req_addr[ADDR_W-1 -: TAG_W];
    assign req_set    = req_addr[2 + OFF_W +: SET_W];
    assign req_off    = req_addr[2 +: OFF_W];
    assign block_addr = {req_addr[ADDR_W-1:OFF_W+2], {(OFF_W + 2){1'b0}}};

    assign mem_req = '{request: mem_request, addr: block_addr};

    // Compare every way of the set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[req_set][w] && tag_mem[req_set][w] == req_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign fill = (state == REFILL) && fill_done;

    icache_replace #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) u_replace (
        .Clk        (Clk),
        .rst        (rst),
        .set        (req_set),
        .valid_ways (valid_q[req_set]),
        .fill       (fill),
        .victim     (victim)
    );

    always_ff @(posedge Clk) begin
        if (rst) begin
            state       <= IDLE;
            ready       <= 1'b0;
            busy        <= 1'b0;
            mem_request <= 1'b0;
            fill_cnt    <= '0;
            fill_done   <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else begin
            ready <= 1'b0;
            case (state)
                IDLE: begin
                    if (read_enable && !ready) begin // Skip the ready cycle
                        busy  <= 1'b1;
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        ready <= 1'b1;
                        busy  <= 1'b0;
                        state <= IDLE;
                    end else begin
                        mem_request <= 1'b1;
                        fill_cnt    <= '0;
                        state       <= REFILL;
                    end
                end
                REFILL: begin
                    if (fill_done) begin
                        valid_q[req_set][victim] <= 1'b1;
                        fill_done <= 1'b0;
                        ready     <= 1'b1;
                        busy      <= 1'b0;
                        state     <= IDLE;
                    end else if (mem_rsp.data_ready) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (fill_cnt == offset_t'(BLOCK_WORDS - 1)) begin
                            mem_request <= 1'b0; // Drop on the last beat
                            fill_done   <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (state == IDLE && read_enable && !ready) begin
            req_addr <= read_address;
        end
        if (state == LOOKUP && hit) begin
            instruction <= data_mem[req_set][hit_way][req_off];
        end
        if (state == REFILL && !fill_done && mem_rsp.data_ready) begin
            fill_buf[fill_cnt] <= mem_rsp.data;
        end
        if (fill) begin
            tag_mem[req_set][victim] <= req_tag;
            for (int b = 0; b < BLOCK_WORDS; b++) begin
                data_mem[req_set][victim][b] <= fill_buf[b];
            end
            instruction <= fill_buf[req_off];
        end
    end

endmodule

/* source/icache_subsys.sv */
module icache_subsys #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4,
    parameter int MEM_WORDS   = 1024,
    parameter int MEM_LATENCY = 3
) (
    input  logic                  Clk,
    input  logic                  rst,
    input  logic                  read_enable,
    input  icache_pkg::addr_t     read_address,
    output icache_pkg::word_t     instruction,
    output logic                  ready,
    output logic                  busy,
    input  icache_pkg::load_req_t load
);

    import icache_pkg::*;

    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    icache #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_icache (
        .Clk          (Clk),
        .rst          (rst),
        .read_enable  (read_enable),
        .read_address (read_address),
        .instruction  (instruction),
        .ready        (ready),
        .busy         (busy),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp)
    );

    // Stands in for the SDRAM controller
    sdram_block_reader #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_reader (
        .Clk     (Clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp),
        .load    (load)
    );

endmodule

/* sim/icache_subsys_tb.sv */
module icache_subsys_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import icache_pkg::*;

    localparam int NUM_SETS    = 8;
    localparam int NUM_WAYS    = 4;
    localparam int BLOCK_WORDS = 4;
    localparam int MEM_WORDS   = 1024;
    localparam int MEM_LATENCY = 3;
    localparam int OFF_W       = $clog2(BLOCK_WORDS);
    localparam int SET_W       = $clog2(NUM_SETS);
    localparam int SET_STRIDE  = NUM_SETS * BLOCK_WORDS * 4; // Bytes between blocks of one set
    localparam int HIT_EDGES   = 2;   // Drive edge up to the edge that registers ready
    localparam int WAIT_LIMIT  = 200;

    typedef struct packed {
        logic  do_reset; // Reset instead of a fetch
        addr_t addr;
    } stim_t;

    logic      Clk = 1'b0;
    logic      rst;
    logic      read_enable;
    addr_t     read_address;
    word_t     instruction;
    logic      ready;
    logic      busy;
    load_req_t load;

    word_t       image [MEM_WORDS];
    stim_t       stim_q [$];
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    logic        timed_out;

    // Reference cache state
    logic [31:0]         model_tag [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] model_valid [NUM_SETS];
    int                  model_rr [NUM_SETS];

    always #4 Clk = ~Clk;

    icache_subsys u_icache_subsys (
        .Clk          (Clk),
        .rst          (rst),
        .read_enable  (read_enable),
        .read_address (read_address),
        .instruction  (instruction),
        .ready        (ready),
        .busy         (busy),
        .load         (load)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic compare_values(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic model_clear();
        for (int s = 0; s < NUM_SETS; s++) begin
            model_valid[s] = '0;
            model_rr[s]    = 0;
        end
    endtask

    // Predicts hit or miss and fills the model on a miss
    task automatic model_access(input addr_t a, output logic hit);
        int          s;
        int          way;
        logic [31:0] tag;
        s   = int'(a[2 + OFF_W +: SET_W]);
        tag = a >> (2 + OFF_W + SET_W);
        hit = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == tag) begin
                hit = 1'b1;
            end
        end
        if (!hit) begin
            way = -1;
            for (int w = 0; w < NUM_WAYS && way < 0; w++) begin
                if (!model_valid[s][w]) way = w;
            end
            if (way < 0) begin // Set full, round robin
                way         = model_rr[s];
                model_rr[s] = (model_rr[s] + 1) % NUM_WAYS;
            end
            model_tag[s][way]   = tag;
            model_valid[s][way] = 1'b1;
        end
    endtask

    // Called on a rising edge or at time zero
    task automatic apply_reset();
        rst         <= 1'b1;
        read_enable <= 1'b0;
        repeat (2) @(posedge Clk);
        rst <= 1'b0;
        model_clear();
        repeat (2) begin
            @(negedge Clk);
            compare_values("ready after reset", ready, 0);
            compare_values("busy after reset", busy, 0);
        end
    endtask

    task automatic load_image();
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(posedge Clk);
            load <= '{we: 1'b1, addr: addr_t'(i * 4), data: image[i]};
        end
        @(posedge Clk);
        load <= '0;
    endtask

    // Edges counted from the drive edge
    task automatic wait_ready(input addr_t a, output int edges);
        edges = 0;
        do begin
            @(posedge Clk);
            edges++;
            @(negedge Clk);
            if (!ready) compare_values("busy while waiting", busy, 1);
        end while (!ready && edges < WAIT_LIMIT);
        if (!ready) begin
            timed_out = 1'b1;
            $display("Timeout: no ready within %0d cycles for address %h", WAIT_LIMIT, a);
        end
    endtask

    task automatic fetch(input addr_t a);
        logic  exp_hit;
        int    edges;
        word_t exp_word;
        model_access(a, exp_hit);
        exp_word = image[(a >> 2) % MEM_WORDS];
        @(posedge Clk);
        read_enable  <= 1'b1;
        read_address <= a;
        wait_ready(a, edges);
        if (!timed_out) begin
            compare_values($sformatf("instruction at %h", a), instruction, exp_word);
            compare_values("busy with ready", busy, 0);
            if (exp_hit) begin
                compare_values($sformatf("hit latency at %h", a), edges, HIT_EDGES);
            end else begin
                compare_values($sformatf("miss slower than burst at %h", a),
                               edges > MEM_LATENCY + BLOCK_WORDS, 1);
            end
            @(posedge Clk);
            read_enable <= 1'b0; // Cache ignores this edge anyway
        end
    endtask

    task automatic add_fetch(input addr_t a);
        stim_q.push_back('{do_reset: 1'b0, addr: a});
    endtask

    task automatic build_table();
        logic [31:0] r;
        // Cold miss, then the rest of the block
        add_fetch(32'h0000_0048);
        add_fetch(32'h0000_0040);
        add_fetch(32'h0000_0044);
        add_fetch(32'h0000_004C);
        add_fetch(32'h0000_0048);
        // Six blocks in set 1: forward, backward, forward
        for (int k = 0; k < NUM_WAYS + 2; k++) begin
            add_fetch(addr_t'(32'h10 + k * SET_STRIDE + (k % BLOCK_WORDS) * 4));
        end
        for (int k = NUM_WAYS + 1; k >= 0; k--) begin
            add_fetch(addr_t'(32'h10 + k * SET_STRIDE + (k % BLOCK_WORDS) * 4));
        end
        for (int k = 0; k < NUM_WAYS + 2; k++) begin
            add_fetch(addr_t'(32'h1C + k * SET_STRIDE));
        end
        // Random words over the first quarter of the image
        for (int i = 0; i < 32; i++) begin
            draw_bits(8, r);
            add_fetch(r << 2);
        end
        add_fetch(32'h0000_0048); // Random fetches may have evicted it
        stim_q.push_back('{do_reset: 1'b1, addr: '0});
        add_fetch(32'h0000_0048); // Resident before the reset
        add_fetch(32'h0000_0044);
        add_fetch(32'h0000_0048);
    endtask

    initial begin
        logic [31:0] w;
        errors       = 0;
        checks       = 0;
        timed_out    = 1'b0;
        lfsr         = 32'hf4b4_6ca4;
        rst          = 1'b1;
        read_enable  = 1'b0;
        read_address = '0;
        load         = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            draw_bits(32, w);
            image[i] = w;
        end
        build_table();
        apply_reset();
        load_image();
        foreach (stim_q[i]) begin
            if (!timed_out) begin
                if (stim_q[i].do_reset) begin
                    apply_reset();
                end else begin
                    fetch(stim_q[i].addr);
                end
            end
        end
        $display("Checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* icache_subsys.f */
source/icache_pkg.sv
source/icache_replace.sv
source/sdram_block_reader.sv
source/icache.sv
source/icache_subsys.sv
sim/icache_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f icache_subsys.f \
    --top-module icache_subsys_tb \
    -Mdir obj_dir -o icache_subsys_sim

./obj_dir/icache_subsys_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation passed"
exit 0
